/* verilog/encoder_pkg.sv */
package encoder_pkg;

    //////////////////////////////////////////////////
    // Symbols
    //////////////////////////////////////////////////

    typedef logic [7:0] sym_t;  // One text or vocabulary character.

    // Ends a word in the text and pads the unused tail of a vocabulary entry.
    localparam sym_t SYM_END = 8'h00;

    //////////////////////////////////////////////////
    // State machines
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        M_IDLE,
        M_FETCH,     // Request the text symbol, address the vocabulary.
        M_COMPARE,   // Both symbols arrive here.
        M_NEXT,
        M_REPORT
    } match_state_t;

    typedef enum logic [2:0] {
        E_IDLE,
        E_READ_START,  // Look at the first symbol of the current word.
        E_RUN_MATCH,
        E_EMIT,
        E_SKIP,        // Walk forward past the terminator.
        E_FINISH
    } enc_state_t;

endpackage

/* verilog/mem_rd_if.sv */
interface mem_rd_if import encoder_pkg::*; #(
    parameter int ADDR_WIDTH = 6
);
    logic                  req;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  gnt;
    logic                  rvalid;  // One cycle after gnt, to the granted side only.
    sym_t                  rdata;

    modport requester (
        output req,
        output addr,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  addr,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

/* verilog/sym_ram.sv */
module sym_ram import encoder_pkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  sym_t                  wdata,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output sym_t                  rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    sym_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // Registered read, data follows the address by one cycle.
    end

endmodule

/* verilog/text_port_arbiter.sv */
module text_port_arbiter import encoder_pkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    mem_rd_if.arbiter             mtc,
    mem_rd_if.arbiter             ctl,
    output logic [ADDR_WIDTH-1:0] ram_addr,
    input  sym_t                  ram_rdata
);

    logic rd_pending;  // A read was granted last cycle.
    logic rd_to_mtc;   // It went to the matcher.

    // The matcher wins a tie.
    always_comb begin
        mtc.gnt  = mtc.req;
        ctl.gnt  = ctl.req && !mtc.req;
        ram_addr = mtc.req ? mtc.addr : ctl.addr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
            rd_to_mtc  <= 1'b0;
        end else begin
            rd_pending <= mtc.req || ctl.req;
            rd_to_mtc  <= mtc.req;
        end
    end

    //////////////////////////////////////////////////
    // Return path
    //////////////////////////////////////////////////

    assign mtc.rvalid = rd_pending && rd_to_mtc;
    assign ctl.rvalid = rd_pending && !rd_to_mtc;
    assign mtc.rdata  = ram_rdata;
    assign ctl.rdata  = ram_rdata;

endmodule

/* verilog/vocab_matcher.sv */
module vocab_matcher import encoder_pkg::*; #(
    parameter int ADDR_WIDTH      = 6,
    parameter int VOCAB_ENTRIES   = 16,
    parameter int ENTRY_LEN       = 8,
    localparam int IDX_WIDTH      = $clog2(VOCAB_ENTRIES),
    localparam int OFF_WIDTH      = $clog2(ENTRY_LEN),
    localparam int VADDR_WIDTH    = IDX_WIDTH + OFF_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   match_start,
    input  logic [ADDR_WIDTH-1:0]  word_addr,
    mem_rd_if.requester            text,
    output logic [VADDR_WIDTH-1:0] vocab_addr,
    input  sym_t                   vocab_rdata,
    output logic                   match_done,
    output logic                   match_found,
    output logic [IDX_WIDTH-1:0]   match_index
);

    typedef logic [ADDR_WIDTH-1:0] text_addr_t;
    typedef logic [IDX_WIDTH-1:0]  idx_t;
    typedef logic [OFF_WIDTH-1:0]  off_t;

    match_state_t state;
    text_addr_t   base;    // First symbol of the word under test.
    idx_t         entry;
    off_t         offset;
    logic         found;

    // Text and vocabulary are read at the same offset in the same cycle.
    assign text.req    = (state == M_FETCH);
    assign text.addr   = base + text_addr_t'(offset);
    assign vocab_addr  = {entry, offset};

    assign match_done  = (state == M_REPORT);
    assign match_found = found;
    assign match_index = entry;

    always_ff @(posedge clk) begin
        if (state == M_IDLE && match_start) begin
            base <= word_addr;
        end
    end

    //////////////////////////////////////////////////
    // Entry walk
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= M_IDLE;
            entry  <= '0;
            offset <= '0;
            found  <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (match_start) begin
                        entry  <= '0;
                        offset <= '0;
                        found  <= 1'b0;
                        state  <= M_FETCH;
                    end
                end
                M_FETCH: begin
                    if (text.gnt) begin
                        state <= M_COMPARE;
                    end
                end
                M_COMPARE: begin
                    if (text.rvalid) begin
                        if (text.rdata != vocab_rdata) begin
                            state <= M_NEXT;
                        end else if (text.rdata == SYM_END) begin
                            found <= 1'b1;  // Both ended together.
                            state <= M_REPORT;
                        end else if (offset == off_t'(ENTRY_LEN - 1)) begin
                            // The word runs past the entry, so it cannot match.
                            state <= M_NEXT;
                        end else begin
                            offset <= offset + 1'b1;
                            state  <= M_FETCH;
                        end
                    end
                end
                M_NEXT: begin
                    offset <= '0;
                    if (entry == idx_t'(VOCAB_ENTRIES - 1)) begin
                        entry <= '0;  // Not found reports index zero.
                        state <= M_REPORT;
                    end else begin
                        entry <= entry + 1'b1;
                        state <= M_FETCH;
                    end
                end
                M_REPORT: state <= M_IDLE;
                default:  state <= M_IDLE;
            endcase
        end
    end

endmodule

/* verilog/word_encoder.sv */
module word_encoder import encoder_pkg::*; #(
    parameter int ADDR_WIDTH    = 6,
    parameter int VOCAB_ENTRIES = 16,
    localparam int IDX_WIDTH    = $clog2(VOCAB_ENTRIES)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    mem_rd_if.requester           text,
    output logic                  match_start,
    output logic [ADDR_WIDTH-1:0] word_addr,
    input  logic                  match_done,
    input  logic                  match_found,
    input  logic [IDX_WIDTH-1:0]  match_index,
    output logic                  token_valid,
    output logic                  token_found,
    output logic [IDX_WIDTH-1:0]  token_id,
    output logic                  busy,
    output logic                  done
);

    typedef logic [ADDR_WIDTH-1:0] text_addr_t;

    enc_state_t state;
    text_addr_t pos;
    logic       rd_wait;   // Granted, data not yet back.
    logic       last_pos;

    assign last_pos  = (pos == '1);
    assign word_addr = pos;

    // Both reading states ask for the symbol at pos, one read at a time.
    assign text.req  = (state == E_READ_START || state == E_SKIP) && !rd_wait;
    assign text.addr = pos;

    assign token_valid = (state == E_EMIT);
    assign done        = (state == E_FINISH);
    assign busy        = (state != E_IDLE);

    always_ff @(posedge clk) begin
        if (state == E_RUN_MATCH && match_done) begin
            token_found <= match_found;
            token_id    <= match_index;
        end
    end

    //////////////////////////////////////////////////
    // Text walk
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= E_IDLE;
            pos         <= '0;
            rd_wait     <= 1'b0;
            match_start <= 1'b0;
        end else begin
            match_start <= 1'b0;
            if (text.gnt) begin
                rd_wait <= 1'b1;
            end
            if (text.rvalid) begin
                rd_wait <= 1'b0;
            end
            case (state)
                E_IDLE: begin
                    if (start) begin
                        pos   <= '0;
                        state <= E_READ_START;
                    end
                end
                E_READ_START: begin
                    if (text.rvalid) begin
                        if (text.rdata == SYM_END) begin
                            state <= E_FINISH;  // Empty word ends the text.
                        end else begin
                            match_start <= 1'b1;
                            state       <= E_RUN_MATCH;
                        end
                    end
                end
                E_RUN_MATCH: begin
                    if (match_done) begin
                        state <= E_EMIT;
                    end
                end
                E_EMIT: begin
                    if (last_pos) begin
                        state <= E_FINISH;
                    end else begin
                        pos   <= pos + 1'b1;
                        state <= E_SKIP;
                    end
                end
                E_SKIP: begin
                    if (text.rvalid) begin
                        if (last_pos) begin
                            state <= E_FINISH;  // No room left after this symbol.
                        end else begin
                            pos <= pos + 1'b1;
                            if (text.rdata == SYM_END) begin
                                state <= E_READ_START;
                            end
                        end
                    end
                end
                E_FINISH: state <= E_IDLE;
                default:  state <= E_IDLE;
            endcase
        end
    end

endmodule

/* verilog/encoder_top.sv */
module encoder_top import encoder_pkg::*; #(
    parameter int TEXT_ADDR_WIDTH   = 6,
    parameter int VOCAB_ENTRIES     = 16,
    parameter int ENTRY_LEN         = 8,
    localparam int VOCAB_ADDR_WIDTH = $clog2(VOCAB_ENTRIES * ENTRY_LEN),
    localparam int TOKEN_WIDTH      = $clog2(VOCAB_ENTRIES)
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        text_we,
    input  logic [TEXT_ADDR_WIDTH-1:0]  text_waddr,
    input  sym_t                        text_wdata,
    input  logic                        vocab_we,
    input  logic [VOCAB_ADDR_WIDTH-1:0] vocab_waddr,
    input  sym_t                        vocab_wdata,
    input  logic                        start,
    output logic                        token_valid,
    output logic                        token_found,
    output logic [TOKEN_WIDTH-1:0]      token_id,
    output logic                        busy,
    output logic                        done
);

    logic [TEXT_ADDR_WIDTH-1:0]  text_raddr;
    sym_t                        text_rdata;
    logic [VOCAB_ADDR_WIDTH-1:0] vocab_raddr;
    sym_t                        vocab_rdata;

    logic                        match_start;
    logic [TEXT_ADDR_WIDTH-1:0]  word_addr;
    logic                        match_done;
    logic                        match_found;
    logic [TOKEN_WIDTH-1:0]      match_index;

    // Matcher and controller share the single text read port.
    mem_rd_if #(.ADDR_WIDTH(TEXT_ADDR_WIDTH)) mtc_if ();
    mem_rd_if #(.ADDR_WIDTH(TEXT_ADDR_WIDTH)) ctl_if ();

    sym_ram #(.ADDR_WIDTH(TEXT_ADDR_WIDTH)) text_ram (
        .clk   (clk),
        .we    (text_we),
        .waddr (text_waddr),
        .wdata (text_wdata),
        .raddr (text_raddr),
        .rdata (text_rdata)
    );

    sym_ram #(.ADDR_WIDTH(VOCAB_ADDR_WIDTH)) vocab_ram (
        .clk   (clk),
        .we    (vocab_we),
        .waddr (vocab_waddr),
        .wdata (vocab_wdata),
        .raddr (vocab_raddr),
        .rdata (vocab_rdata)
    );

    text_port_arbiter #(.ADDR_WIDTH(TEXT_ADDR_WIDTH)) u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .mtc       (mtc_if.arbiter),
        .ctl       (ctl_if.arbiter),
        .ram_addr  (text_raddr),
        .ram_rdata (text_rdata)
    );

    vocab_matcher #(
        .ADDR_WIDTH    (TEXT_ADDR_WIDTH),
        .VOCAB_ENTRIES (VOCAB_ENTRIES),
        .ENTRY_LEN     (ENTRY_LEN)
    ) u_matcher (
        .clk         (clk),
        .rst_n       (rst_n),
        .match_start (match_start),
        .word_addr   (word_addr),
        .text        (mtc_if.requester),
        .vocab_addr  (vocab_raddr),
        .vocab_rdata (vocab_rdata),
        .match_done  (match_done),
        .match_found (match_found),
        .match_index (match_index)
    );

    word_encoder #(
        .ADDR_WIDTH    (TEXT_ADDR_WIDTH),
        .VOCAB_ENTRIES (VOCAB_ENTRIES)
    ) u_encoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .text        (ctl_if.requester),
        .match_start (match_start),
        .word_addr   (word_addr),
        .match_done  (match_done),
        .match_found (match_found),
        .match_index (match_index),
        .token_valid (token_valid),
        .token_found (token_found),
        .token_id    (token_id),
        .busy        (busy),
        .done        (done)
    );

endmodule

/* sim/tb_encoder.sv */
module tb_encoder import encoder_pkg::*; ();

    localparam int TEXT_ADDR_WIDTH  = 6;
    localparam int VOCAB_ENTRIES    = 16;
    localparam int ENTRY_LEN        = 8;
    localparam int TEXT_DEPTH       = 2 ** TEXT_ADDR_WIDTH;
    localparam int VOCAB_DEPTH      = VOCAB_ENTRIES * ENTRY_LEN;
    localparam int VOCAB_ADDR_WIDTH = $clog2(VOCAB_DEPTH);
    localparam int TOKEN_WIDTH      = $clog2(VOCAB_ENTRIES);
    localparam int RUN_TIMEOUT      = 50000;

    logic                        clk;
    logic                        rst_n;
    logic                        text_we;
    logic [TEXT_ADDR_WIDTH-1:0]  text_waddr;
    sym_t                        text_wdata;
    logic                        vocab_we;
    logic [VOCAB_ADDR_WIDTH-1:0] vocab_waddr;
    sym_t                        vocab_wdata;
    logic                        start;
    logic                        token_valid;
    logic                        token_found;
    logic [TOKEN_WIDTH-1:0]      token_id;
    logic                        busy;
    logic                        done;

    logic [31:0] rng;
    sym_t        text_mem  [TEXT_DEPTH];   // Image of the text memory.
    sym_t        vocab_mem [VOCAB_DEPTH];
    sym_t        wbuf      [16];           // Word under construction.
    int          wlen;
    int          exp_q     [$];            // Bit 8 is found, low bits the index.

    encoder_top #(
        .TEXT_ADDR_WIDTH (TEXT_ADDR_WIDTH),
        .VOCAB_ENTRIES   (VOCAB_ENTRIES),
        .ENTRY_LEN       (ENTRY_LEN)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .text_we     (text_we),
        .text_waddr  (text_waddr),
        .text_wdata  (text_wdata),
        .vocab_we    (vocab_we),
        .vocab_waddr (vocab_waddr),
        .vocab_wdata (vocab_wdata),
        .start       (start),
        .token_valid (token_valid),
        .token_found (token_found),
        .token_id    (token_id),
        .busy        (busy),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Random numbers and checks
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng = xorshift32(rng);
        return rng % n;
    endfunction

    // A small alphabet makes shared prefixes and duplicates likely.
    function automatic sym_t random_sym();
        return sym_t'(32'h61 + rand_below(3));
    endfunction

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic compare_values(input logic [31:0] got, input logic [31:0] expected,
                                  input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, expected);
            stop_on_error();
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////

    function automatic int entry_len(input int e);
        int n;
        n = 0;
        while (n < ENTRY_LEN && vocab_mem[e * ENTRY_LEN + n] != SYM_END) n++;
        return n;
    endfunction

    task automatic fill_vocab(input bit dups);
        int e;
        int k;
        int len;
        int src;
        int dst;
        for (e = 0; e < VOCAB_ENTRIES; e++) begin
            len = 1 + rand_below(ENTRY_LEN);  // A full entry can never match.
            for (k = 0; k < ENTRY_LEN; k++) begin
                vocab_mem[e * ENTRY_LEN + k] = (k < len) ? random_sym() : SYM_END;
            end
        end
        if (dups) begin
            repeat (3) begin
                src = rand_below(VOCAB_ENTRIES / 2);
                dst = VOCAB_ENTRIES / 2 + rand_below(VOCAB_ENTRIES / 2);
                for (k = 0; k < ENTRY_LEN; k++) begin
                    vocab_mem[dst * ENTRY_LEN + k] = vocab_mem[src * ENTRY_LEN + k];
                end
            end
        end
    endtask

    // Kind 0 copies an entry, 1 a prefix, 2 an extension, 3 a long word, 4 a short one.
    task automatic make_word(input int kind);
        int e;
        int le;
        int k;
        e  = rand_below(VOCAB_ENTRIES);
        le = entry_len(e);
        if (kind == 0 || (kind == 1 && le >= 2) || kind == 2) begin
            wlen = le;
            if (kind == 1) wlen = 1 + rand_below(le - 1);
            if (kind == 2) wlen = le + 1 + rand_below(2);
            for (k = 0; k < wlen; k++) begin
                wbuf[k] = (k < le) ? vocab_mem[e * ENTRY_LEN + k] : random_sym();
            end
        end else begin
            wlen = (kind == 3) ? ENTRY_LEN + rand_below(4) : 1 + rand_below(4);
            for (k = 0; k < wlen; k++) wbuf[k] = random_sym();
        end
    endtask

    task automatic build_text(input int kind_lo, input int kind_hi, input int max_words);
        int pos;
        int n;
        int k;
        int a;
        int words;
        pos   = 0;
        words = (max_words == 0) ? 0 : 1 + rand_below(max_words);
        for (n = 0; n < words; n++) begin
            make_word(kind_lo + rand_below(kind_hi - kind_lo + 1));
            if (pos + wlen + 2 > TEXT_DEPTH) break;  // Keep room for the empty word.
            for (k = 0; k < wlen; k++) text_mem[pos + k] = wbuf[k];
            text_mem[pos + wlen] = SYM_END;
            pos = pos + wlen + 1;
        end
        text_mem[pos] = SYM_END;
        for (a = pos + 1; a < TEXT_DEPTH; a++) begin
            text_mem[a] = sym_t'(32'h80 | a);
        end
    endtask

    // Split the text at terminators and look each word up in the vocabulary.
    task automatic build_model();
        int pos;
        int len;
        int e;
        int k;
        int hit;
        bit same;
        exp_q.delete();
        pos = 0;
        while (pos < TEXT_DEPTH && text_mem[pos] != SYM_END) begin
            len = 0;
            while (pos + len < TEXT_DEPTH && text_mem[pos + len] != SYM_END) len++;
            hit = -1;
            for (e = 0; e < VOCAB_ENTRIES && hit < 0; e++) begin
                same = (len < ENTRY_LEN) && (entry_len(e) == len);
                for (k = 0; k < len && same; k++) begin
                    same = (text_mem[pos + k] == vocab_mem[e * ENTRY_LEN + k]);
                end
                if (same) hit = e;
            end
            exp_q.push_back((hit < 0) ? 0 : (256 | hit));
            pos = pos + len + 1;
        end
    endtask

    task automatic load_memories();
        int a;
        for (a = 0; a < VOCAB_DEPTH; a++) begin
            @(posedge clk);
            text_we     <= (a < TEXT_DEPTH);
            text_waddr  <= TEXT_ADDR_WIDTH'(a);
            text_wdata  <= text_mem[a % TEXT_DEPTH];
            vocab_we    <= 1'b1;
            vocab_waddr <= VOCAB_ADDR_WIDTH'(a);
            vocab_wdata <= vocab_mem[a];
        end
        @(posedge clk);
        text_we  <= 1'b0;
        vocab_we <= 1'b0;
    endtask

    task automatic run_and_check(input bit inject_start);
        int          cycles;
        logic [31:0] expected;
        build_model();
        @(posedge clk);
        start <= 1'b1;
        cycles = 0;
        while (1) begin
            @(posedge clk);
            start <= inject_start && (cycles == 9);  // Must be ignored.
            @(negedge clk);
            compare_values(32'(busy), 32'd1, "busy during a run");
            if (token_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected token at time %0t, the model has no more words.",
                             $time);
                    stop_on_error();
                end
                expected = exp_q.pop_front();
                compare_values(32'(token_found), 32'(expected[8]), "token_found");
                compare_values(32'(token_id), 32'(expected[TOKEN_WIDTH-1:0]), "token_id");
            end
            if (done) break;
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                $display("Timeout: done did not arrive within %0d cycles.", RUN_TIMEOUT);
                stop_on_error();
            end
        end
        if (exp_q.size() != 0) begin
            $display("Token count mismatch: %0d expected tokens never came out.",
                     exp_q.size());
            stop_on_error();
        end
        @(negedge clk);
        compare_values(32'(busy), 32'd0, "busy after done");
        compare_values(32'(done), 32'd0, "done in the cycle after done");
        compare_values(32'(token_valid), 32'd0, "token_valid after done");
    endtask

    task automatic run_scenario(input int kind_lo, input int kind_hi, input int max_words,
                                input bit dups, input bit inject_start);
        fill_vocab(dups);
        build_text(kind_lo, kind_hi, max_words);
        load_memories();
        run_and_check(inject_start);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int i;
        rng         = 32'd88438;
        rst_n       = 1'b0;
        start       = 1'b0;
        text_we     = 1'b0;
        text_waddr  = '0;
        text_wdata  = SYM_END;
        vocab_we    = 1'b0;
        vocab_waddr = '0;
        vocab_wdata = SYM_END;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Nothing moves before the first start.
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            compare_values(32'(token_valid), 32'd0, "token_valid before start");
            compare_values(32'(busy), 32'd0, "busy before start");
            compare_values(32'(done), 32'd0, "done before start");
        end

        run_scenario(0, 0, 10, 1'b1, 1'b0);  // Vocabulary words with duplicates.
        run_scenario(1, 4, 10, 1'b0, 1'b0);  // Mostly absent words.
        run_scenario(0, 0, 0, 1'b0, 1'b0);   // Empty text.

        for (i = 0; i < 6; i++) begin
            run_scenario(0, 4, 14, 1'(rand_below(2)), 1'(i % 2));
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* src.f */
verilog/encoder_pkg.sv
verilog/mem_rd_if.sv
verilog/sym_ram.sv
verilog/text_port_arbiter.sv
verilog/vocab_matcher.sv
verilog/word_encoder.sv
verilog/encoder_top.sv
sim/tb_encoder.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_encoder
FILELIST  = src.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
